/* Makefile */
# Verilator build and run for the core bus testbench

VERILATOR := verilator
FLAGS     := --binary -j 0 --assert --timing
TOP       := core_bus_tb
FILELIST  := core_bus.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* core_bus.f */
+incdir+include
design/core_bus_pkg.sv
design/core_bus_arbiter.sv
design/core_bus_xbar.sv
design/core_bus_clint.sv
design/core_bus_top.sv
dv/core_bus_props.sv
dv/core_bus_tb.sv

/* design/core_bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bus_arbiter (
	input  wire                          clock,
	input  wire                          rst_n_i,

	// instruction fetch master
	input  wire                          ifu_req_valid_i,
	input  wire core_bus_pkg::bus_req_t  ifu_req_i,
	output logic                         ifu_req_ready_o,
	output logic                         ifu_resp_valid_o,
	output core_bus_pkg::bus_resp_t      ifu_resp_o,
	input  wire                          ifu_resp_ready_i,

	// load/store master
	input  wire                          lsu_req_valid_i,
	input  wire core_bus_pkg::bus_req_t  lsu_req_i,
	output logic                         lsu_req_ready_o,
	output logic                         lsu_resp_valid_o,
	output core_bus_pkg::bus_resp_t      lsu_resp_o,
	input  wire                          lsu_resp_ready_i,

	// system bus towards the crossbar
	output logic                         bus_req_valid_o,
	output core_bus_pkg::bus_req_t       bus_req_o,
	input  wire                          bus_req_ready_i,
	input  wire                          bus_resp_valid_i,
	input  wire core_bus_pkg::bus_resp_t bus_resp_i,
	output logic                         bus_resp_ready_o
);
	import core_bus_pkg::*;

	arb_state_e state_q;
	logic       last_lsu_q;
	logic       pend_q;
	logic       pend_lsu_q;
	logic       pick_lsu;
	logic       any_req;
	logic       req_fire;
	logic       resp_fire;

	assign any_req = ifu_req_valid_i | lsu_req_valid_i;

	// --------------------------------------------------
	// request side
	// --------------------------------------------------
	// round-robin on a tie, choice locked while downstream stalls
	always_comb begin
		if (pend_q) begin
			pick_lsu = pend_lsu_q;
		end else if (ifu_req_valid_i && lsu_req_valid_i) begin
			pick_lsu = !last_lsu_q;
		end else begin
			pick_lsu = lsu_req_valid_i;
		end
	end

	// request forwarded combinationally, only while idle
	assign bus_req_valid_o = (state_q == ARB_IDLE) && any_req;
	assign bus_req_o       = pick_lsu ? lsu_req_i : ifu_req_i;
	assign req_fire        = bus_req_valid_o && bus_req_ready_i;
	assign ifu_req_ready_o = req_fire && !pick_lsu;
	assign lsu_req_ready_o = req_fire && pick_lsu;

	// --------------------------------------------------
	// response side
	// --------------------------------------------------
	assign ifu_resp_valid_o = (state_q == ARB_IFU) && bus_resp_valid_i;
	assign lsu_resp_valid_o = (state_q == ARB_LSU) && bus_resp_valid_i;
	assign ifu_resp_o       = bus_resp_i;
	assign lsu_resp_o       = bus_resp_i;

	always_comb begin
		case (state_q)
			ARB_IFU: bus_resp_ready_o = ifu_resp_ready_i;
			ARB_LSU: bus_resp_ready_o = lsu_resp_ready_i;
			default: bus_resp_ready_o = 1'b0;
		endcase
	end

	assign resp_fire = bus_resp_valid_i && bus_resp_ready_o;

	// grant fsm
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= ARB_IDLE;
			last_lsu_q <= 1'b0;
			pend_q     <= 1'b0;
			pend_lsu_q <= 1'b0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (req_fire) begin
						state_q    <= pick_lsu ? ARB_LSU : ARB_IFU;
						last_lsu_q <= pick_lsu;
						pend_q     <= 1'b0;
					end else if (bus_req_valid_o) begin
						// downstream not ready, keep this master
						pend_q     <= 1'b1;
						pend_lsu_q <= pick_lsu;
					end
				end
				ARB_IFU, ARB_LSU: begin
					if (resp_fire) begin
						state_q <= ARB_IDLE;
					end
				end
				default: begin
					state_q <= ARB_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/core_bus_clint.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_bus_defines.svh"

module core_bus_clint (
	input  wire                         clock,
	input  wire                         rst_n_i,

	input  wire                         req_valid_i,
	input  wire core_bus_pkg::bus_req_t req_i,
	output logic                        req_ready_o,
	output logic                        resp_valid_o,
	output core_bus_pkg::bus_resp_t     resp_o,
	input  wire                         resp_ready_i
);
	import core_bus_pkg::*;

	logic [63:0] mtime_q;
	logic        resp_valid_q;
	bus_resp_t   resp_q;
	bus_resp_t   resp_d;
	logic [15:0] offset;
	logic        req_fire;
	logic        hit_lo;
	logic        hit_hi;
	logic        wr_lo;
	logic        wr_hi;

	// replace only the strobed bytes
	function automatic logic [`CB_DATA_W-1:0] merge_bytes(
		input logic [`CB_DATA_W-1:0] old_word,
		input logic [`CB_DATA_W-1:0] new_word,
		input logic [`CB_STRB_W-1:0] strb
	);
		logic [`CB_DATA_W-1:0] word;
		word = old_word;
		for (int i = 0; i < `CB_STRB_W; i++) begin
			if (strb[i]) begin
				word[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return word;
	endfunction

	// one request at a time, blocked while the response waits
	assign req_ready_o = !resp_valid_q;
	assign req_fire    = req_valid_i && req_ready_o;

	assign offset = req_i.addr[15:0];
	assign hit_lo = offset == `CB_MTIME_LO_OFF;
	assign hit_hi = offset == `CB_MTIME_HI_OFF;
	assign wr_lo  = req_fire && (req_i.op == OP_WRITE) && hit_lo;
	assign wr_hi  = req_fire && (req_i.op == OP_WRITE) && hit_hi;

	always_comb begin
		resp_d.rdata = '0;
		resp_d.resp  = RESP_OKAY;
		if (hit_lo) begin
			if (req_i.op == OP_READ) begin
				resp_d.rdata = mtime_q[31:0];
			end
		end else if (hit_hi) begin
			if (req_i.op == OP_READ) begin
				resp_d.rdata = mtime_q[63:32];
			end
		end else begin
			resp_d.resp = RESP_SLVERR;
		end
	end

	// --------------------------------------------------
	// mtime, counts unless software loads it
	// --------------------------------------------------
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime_q <= '0;
		end else if (wr_lo) begin
			mtime_q[31:0] <= merge_bytes(mtime_q[31:0], req_i.wdata, req_i.wstrb);
		end else if (wr_hi) begin
			mtime_q[63:32] <= merge_bytes(mtime_q[63:32], req_i.wdata, req_i.wstrb);
		end else begin
			mtime_q <= mtime_q + 64'd1;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			resp_valid_q <= 1'b0;
		end else if (req_fire) begin
			resp_valid_q <= 1'b1;
		end else if (resp_ready_i) begin
			resp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			resp_q <= resp_d;
		end
	end

	assign resp_valid_o = resp_valid_q;
	assign resp_o       = resp_q;

endmodule

`default_nettype wire

/* design/core_bus_pkg.sv */
`default_nettype none

`include "core_bus_defines.svh"

package core_bus_pkg;

	// transfer direction
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// response codes, same encoding as axi
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} bus_resp_e;

	// arbiter grant state
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_IFU  = 2'd1,
		ARB_LSU  = 2'd2
	} arb_state_e;

	// --------------------------------------------------
	// channel payloads, one beat of one word
	// --------------------------------------------------
	typedef struct packed {
		bus_op_e               op;
		logic [`CB_ADDR_W-1:0] addr;
		logic [`CB_DATA_W-1:0] wdata;
		logic [`CB_STRB_W-1:0] wstrb;
	} bus_req_t;

	typedef struct packed {
		logic [`CB_DATA_W-1:0] rdata;
		bus_resp_e             resp;
	} bus_resp_t;

endpackage

`default_nettype wire

/* design/core_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_bus_top (
	input  wire                          clock,
	input  wire                          rst_n_i,

	// instruction fetch port
	input  wire                          ifu_req_valid_i,
	input  wire core_bus_pkg::bus_req_t  ifu_req_i,
	output logic                         ifu_req_ready_o,
	output logic                         ifu_resp_valid_o,
	output core_bus_pkg::bus_resp_t      ifu_resp_o,
	input  wire                          ifu_resp_ready_i,

	// load/store port
	input  wire                          lsu_req_valid_i,
	input  wire core_bus_pkg::bus_req_t  lsu_req_i,
	output logic                         lsu_req_ready_o,
	output logic                         lsu_resp_valid_o,
	output core_bus_pkg::bus_resp_t      lsu_resp_o,
	input  wire                          lsu_resp_ready_i,

	// external memory port
	output logic                         mem_req_valid_o,
	output core_bus_pkg::bus_req_t       mem_req_o,
	input  wire                          mem_req_ready_i,
	input  wire                          mem_resp_valid_i,
	input  wire core_bus_pkg::bus_resp_t mem_resp_i,
	output logic                         mem_resp_ready_o
);
	import core_bus_pkg::*;

	// --------------------------------------------------
	// arbiter to crossbar
	// --------------------------------------------------
	logic      bus_req_valid;
	bus_req_t  bus_req;
	logic      bus_req_ready;
	logic      bus_resp_valid;
	bus_resp_t bus_resp;
	logic      bus_resp_ready;

	// crossbar to clint
	logic      clint_req_valid;
	bus_req_t  clint_req;
	logic      clint_req_ready;
	logic      clint_resp_valid;
	bus_resp_t clint_resp;
	logic      clint_resp_ready;

	core_bus_arbiter u_arbiter (
		.clock            (clock),
		.rst_n_i          (rst_n_i),
		.ifu_req_valid_i  (ifu_req_valid_i),
		.ifu_req_i        (ifu_req_i),
		.ifu_req_ready_o  (ifu_req_ready_o),
		.ifu_resp_valid_o (ifu_resp_valid_o),
		.ifu_resp_o       (ifu_resp_o),
		.ifu_resp_ready_i (ifu_resp_ready_i),
		.lsu_req_valid_i  (lsu_req_valid_i),
		.lsu_req_i        (lsu_req_i),
		.lsu_req_ready_o  (lsu_req_ready_o),
		.lsu_resp_valid_o (lsu_resp_valid_o),
		.lsu_resp_o       (lsu_resp_o),
		.lsu_resp_ready_i (lsu_resp_ready_i),
		.bus_req_valid_o  (bus_req_valid),
		.bus_req_o        (bus_req),
		.bus_req_ready_i  (bus_req_ready),
		.bus_resp_valid_i (bus_resp_valid),
		.bus_resp_i       (bus_resp),
		.bus_resp_ready_o (bus_resp_ready)
	);

	core_bus_xbar u_xbar (
		.clock              (clock),
		.rst_n_i            (rst_n_i),
		.up_req_valid_i     (bus_req_valid),
		.up_req_i           (bus_req),
		.up_req_ready_o     (bus_req_ready),
		.up_resp_valid_o    (bus_resp_valid),
		.up_resp_o          (bus_resp),
		.up_resp_ready_i    (bus_resp_ready),
		.mem_req_valid_o    (mem_req_valid_o),
		.mem_req_o          (mem_req_o),
		.mem_req_ready_i    (mem_req_ready_i),
		.mem_resp_valid_i   (mem_resp_valid_i),
		.mem_resp_i         (mem_resp_i),
		.mem_resp_ready_o   (mem_resp_ready_o),
		.clint_req_valid_o  (clint_req_valid),
		.clint_req_o        (clint_req),
		.clint_req_ready_i  (clint_req_ready),
		.clint_resp_valid_i (clint_resp_valid),
		.clint_resp_i       (clint_resp),
		.clint_resp_ready_o (clint_resp_ready)
	);

	core_bus_clint u_clint (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.req_valid_i  (clint_req_valid),
		.req_i        (clint_req),
		.req_ready_o  (clint_req_ready),
		.resp_valid_o (clint_resp_valid),
		.resp_o       (clint_resp),
		.resp_ready_i (clint_resp_ready)
	);

endmodule

`default_nettype wire

/* design/core_bus_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_bus_defines.svh"

module core_bus_xbar (
	input  wire                          clock,
	input  wire                          rst_n_i,

	// upstream port from the arbiter
	input  wire                          up_req_valid_i,
	input  wire core_bus_pkg::bus_req_t  up_req_i,
	output logic                         up_req_ready_o,
	output logic                         up_resp_valid_o,
	output core_bus_pkg::bus_resp_t      up_resp_o,
	input  wire                          up_resp_ready_i,

	// external memory
	output logic                         mem_req_valid_o,
	output core_bus_pkg::bus_req_t       mem_req_o,
	input  wire                          mem_req_ready_i,
	input  wire                          mem_resp_valid_i,
	input  wire core_bus_pkg::bus_resp_t mem_resp_i,
	output logic                         mem_resp_ready_o,

	// core-local timer
	output logic                         clint_req_valid_o,
	output core_bus_pkg::bus_req_t       clint_req_o,
	input  wire                          clint_req_ready_i,
	input  wire                          clint_resp_valid_i,
	input  wire core_bus_pkg::bus_resp_t clint_resp_i,
	output logic                         clint_resp_ready_o
);
	import core_bus_pkg::*;

	logic      hit_mem;
	logic      hit_clint;
	logic      idle;
	logic      req_fire;
	logic      resp_fire;
	logic      sel_mem_q;
	logic      sel_clint_q;
	logic      fault_q;
	bus_resp_t fault_resp;

	// --------------------------------------------------
	// address decode
	// --------------------------------------------------
	assign hit_mem   = (up_req_i.addr & ~`CB_MEM_MASK) == `CB_MEM_BASE;
	assign hit_clint = (up_req_i.addr & ~`CB_CLINT_MASK) == `CB_CLINT_BASE;

	// no target latched means no transfer in flight
	assign idle = !(sel_mem_q || sel_clint_q || fault_q);

	always_comb begin
		if (!idle) begin
			up_req_ready_o = 1'b0;
		end else if (hit_mem) begin
			up_req_ready_o = mem_req_ready_i;
		end else if (hit_clint) begin
			up_req_ready_o = clint_req_ready_i;
		end else begin
			// unmapped, taken here and answered with a fault
			up_req_ready_o = 1'b1;
		end
	end

	assign req_fire = up_req_valid_i && up_req_ready_o;

	assign mem_req_valid_o   = up_req_valid_i && idle && hit_mem;
	assign mem_req_o         = up_req_i;
	assign clint_req_valid_o = up_req_valid_i && idle && hit_clint;
	assign clint_req_o       = up_req_i;

	// --------------------------------------------------
	// response routing
	// --------------------------------------------------
	assign fault_resp = '{rdata: '0, resp: RESP_DECERR};

	always_comb begin
		if (sel_mem_q) begin
			up_resp_valid_o = mem_resp_valid_i;
			up_resp_o       = mem_resp_i;
		end else if (sel_clint_q) begin
			up_resp_valid_o = clint_resp_valid_i;
			up_resp_o       = clint_resp_i;
		end else begin
			up_resp_valid_o = fault_q;
			up_resp_o       = fault_resp;
		end
	end

	assign mem_resp_ready_o   = sel_mem_q && up_resp_ready_i;
	assign clint_resp_ready_o = sel_clint_q && up_resp_ready_i;
	assign resp_fire          = up_resp_valid_o && up_resp_ready_i;

	// target held from request handshake to response handshake
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sel_mem_q   <= 1'b0;
			sel_clint_q <= 1'b0;
			fault_q     <= 1'b0;
		end else if (req_fire) begin
			sel_mem_q   <= hit_mem;
			sel_clint_q <= !hit_mem && hit_clint;
			fault_q     <= !hit_mem && !hit_clint;
		end else if (resp_fire) begin
			sel_mem_q   <= 1'b0;
			sel_clint_q <= 1'b0;
			fault_q     <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* dv/core_bus_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_bus_defines.svh"

module core_bus_props (
	input wire                          clock,
	input wire                          rst_n_i,
	input wire                          req_valid_i,
	input wire                          req_ready_i,
	input wire core_bus_pkg::bus_req_t  req_i,
	input wire                          resp_valid_i,
	input wire                          resp_ready_i,
	input wire core_bus_pkg::bus_resp_t resp_i,
	// two valids that must never be high together
	input wire                          excl_a_i,
	input wire                          excl_b_i,
	// high where req_* is the external memory port
	input wire                          mem_port_i
);

	int unsigned fail_cnt = 0;

	// --------------------------------------------------
	// handshake rules
	// --------------------------------------------------
	req_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
	else begin
		fail_cnt++;
		$error("request dropped or changed before its handshake");
	end

	resp_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
	else begin
		fail_cnt++;
		$error("response dropped or changed before its handshake");
	end

	// quiet bus while in reset
	reset_idle: assert property (@(posedge clock)
		!rst_n_i |-> !req_valid_i && !resp_valid_i && !excl_a_i && !excl_b_i)
	else begin
		fail_cnt++;
		$error("valid high during reset");
	end

	// window as a plain address range, base up to base plus size
	mem_window: assert property (@(posedge clock) disable iff (!rst_n_i)
		req_valid_i && mem_port_i |-> req_i.addr >= `CB_MEM_BASE
			&& req_i.addr <= `CB_MEM_BASE + `CB_MEM_MASK)
	else begin
		fail_cnt++;
		$error("memory request outside the memory window");
	end

	one_hot: assert property (@(posedge clock) disable iff (!rst_n_i)
		!(excl_a_i && excl_b_i))
	else begin
		fail_cnt++;
		$error("two exclusive valids high together");
	end

endmodule

bind core_bus_arbiter core_bus_props u_arb_props (
	.clock        (clock),
	.rst_n_i      (rst_n_i),
	.req_valid_i  (bus_req_valid_o),
	.req_ready_i  (bus_req_ready_i),
	.req_i        (bus_req_o),
	.resp_valid_i (bus_resp_valid_i),
	.resp_ready_i (bus_resp_ready_o),
	.resp_i       (bus_resp_i),
	.excl_a_i     (ifu_resp_valid_o),
	.excl_b_i     (lsu_resp_valid_o),
	.mem_port_i   (1'b0)
);

bind core_bus_xbar core_bus_props u_xbar_props (
	.clock        (clock),
	.rst_n_i      (rst_n_i),
	.req_valid_i  (mem_req_valid_o),
	.req_ready_i  (mem_req_ready_i),
	.req_i        (mem_req_o),
	.resp_valid_i (mem_resp_valid_i),
	.resp_ready_i (mem_resp_ready_o),
	.resp_i       (mem_resp_i),
	.excl_a_i     (mem_req_valid_o),
	.excl_b_i     (clint_req_valid_o),
	.mem_port_i   (1'b1)
);

`default_nettype wire

/* dv/core_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_bus_defines.svh"

module core_bus_tb;
	import core_bus_pkg::*;

	localparam int          wait_limit    = 50;
	localparam logic [31:0] mtime_lo_addr = `CB_CLINT_BASE | {16'h0000, `CB_MTIME_LO_OFF};
	localparam logic [31:0] mtime_hi_addr = `CB_CLINT_BASE | {16'h0000, `CB_MTIME_HI_OFF};

	logic      clock;
	logic      rst_n;
	logic      ifu_req_valid;
	bus_req_t  ifu_req;
	logic      ifu_req_ready;
	logic      ifu_resp_valid;
	bus_resp_t ifu_resp;
	logic      ifu_resp_ready;
	logic      lsu_req_valid;
	bus_req_t  lsu_req;
	logic      lsu_req_ready;
	logic      lsu_resp_valid;
	bus_resp_t lsu_resp;
	logic      lsu_resp_ready;
	logic      mem_req_valid;
	bus_req_t  mem_req;
	logic      mem_req_ready;
	logic      mem_resp_valid;
	bus_resp_t mem_resp;
	logic      mem_resp_ready;

	int unsigned mismatches    = 0;
	int unsigned timeouts      = 0;
	int unsigned mem_req_count = 0;
	// completion order, 1 for lsu
	bit          done_q[$];
	logic [31:0] mem_words [logic [9:0]];

	core_bus_top u_dut (
		.clock            (clock),
		.rst_n_i          (rst_n),
		.ifu_req_valid_i  (ifu_req_valid),
		.ifu_req_i        (ifu_req),
		.ifu_req_ready_o  (ifu_req_ready),
		.ifu_resp_valid_o (ifu_resp_valid),
		.ifu_resp_o       (ifu_resp),
		.ifu_resp_ready_i (ifu_resp_ready),
		.lsu_req_valid_i  (lsu_req_valid),
		.lsu_req_i        (lsu_req),
		.lsu_req_ready_o  (lsu_req_ready),
		.lsu_resp_valid_o (lsu_resp_valid),
		.lsu_resp_o       (lsu_resp),
		.lsu_resp_ready_i (lsu_resp_ready),
		.mem_req_valid_o  (mem_req_valid),
		.mem_req_o        (mem_req),
		.mem_req_ready_i  (mem_req_ready),
		.mem_resp_valid_i (mem_resp_valid),
		.mem_resp_i       (mem_resp),
		.mem_resp_ready_o (mem_resp_ready)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// unwritten words read as a pattern of the full address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5ca1_ab1e;
	endfunction

	function automatic bus_req_t make_req(input bus_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] wstrb);
		bus_req_t req;
		req.op    = op;
		req.addr  = addr;
		req.wdata = wdata;
		req.wstrb = wstrb;
		return req;
	endfunction

	function automatic bus_resp_t make_resp(input logic [31:0] rdata, input bus_resp_e code);
		bus_resp_t resp;
		resp.rdata = rdata;
		resp.resp  = code;
		return resp;
	endfunction

	function automatic logic req_ready_of(input bit use_lsu);
		return use_lsu ? lsu_req_ready : ifu_req_ready;
	endfunction

	function automatic logic resp_valid_of(input bit use_lsu);
		return use_lsu ? lsu_resp_valid : ifu_resp_valid;
	endfunction

	function automatic logic resp_ready_of(input bit use_lsu);
		return use_lsu ? lsu_resp_ready : ifu_resp_ready;
	endfunction

	function automatic bus_resp_t resp_of(input bit use_lsu);
		return use_lsu ? lsu_resp : ifu_resp;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input bus_resp_t got, input bus_resp_t exp);
		check_val({name, ".rdata"}, got.rdata, exp.rdata);
		check_val({name, ".resp"}, 32'(got.resp), 32'(exp.resp));
	endtask

	task automatic set_req(input bit use_lsu, input logic valid, input bus_req_t req);
		if (use_lsu) begin
			lsu_req_valid = valid;
			lsu_req       = req;
		end else begin
			ifu_req_valid = valid;
			ifu_req       = req;
		end
	endtask

	task automatic set_resp_ready(input bit use_lsu, input logic ready);
		if (use_lsu) begin
			lsu_resp_ready = ready;
		end else begin
			ifu_resp_ready = ready;
		end
	endtask

	// --------------------------------------------------
	// one transfer on one master port
	// --------------------------------------------------
	task automatic run_transfer(input bit use_lsu, input bus_req_t req, input bit stall,
			output bus_resp_t resp);
		string     who;
		int        cycles;
		int        gap;
		bit        seen;
		bus_resp_t first;
		who   = use_lsu ? "lsu" : "ifu";
		resp  = '0;
		first = '0;
		@(negedge clock);
		set_req(use_lsu, 1'b1, req);
		cycles = 0;
		#1;
		while (!req_ready_of(use_lsu)) begin
			if (cycles == wait_limit) begin
				timeouts++;
				$display("%s request was not accepted within %0d cycles", who, wait_limit);
				set_req(use_lsu, 1'b0, '0);
				return;
			end
			cycles++;
			@(negedge clock);
			#1;
		end
		// handshake on the coming rising edge
		@(negedge clock);
		set_req(use_lsu, 1'b0, '0);
		gap = stall ? 1 + int'($urandom % 4) : 0;
		set_resp_ready(use_lsu, gap == 0);
		seen   = 1'b0;
		cycles = 0;
		#1;
		while (!(resp_valid_of(use_lsu) && resp_ready_of(use_lsu))) begin
			if (resp_valid_of(use_lsu)) begin
				if (!seen) begin
					first = resp_of(use_lsu);
					seen  = 1'b1;
				end else begin
					check_resp({who, "_resp_o"}, resp_of(use_lsu), first);
				end
				// held response blocks every new grant
				check_val("ifu_req_ready_o", 32'(ifu_req_ready), 32'd0);
				check_val("lsu_req_ready_o", 32'(lsu_req_ready), 32'd0);
				gap--;
			end
			if (cycles == wait_limit) begin
				timeouts++;
				$display("%s response did not arrive within %0d cycles", who, wait_limit);
				set_resp_ready(use_lsu, 1'b0);
				return;
			end
			cycles++;
			@(negedge clock);
			if (gap <= 0) begin
				set_resp_ready(use_lsu, 1'b1);
			end
			#1;
		end
		resp = resp_of(use_lsu);
		if (seen) begin
			check_resp({who, "_resp_o"}, resp, first);
		end
		done_q.push_back(use_lsu);
		@(negedge clock);
		set_resp_ready(use_lsu, 1'b0);
	endtask

	// --------------------------------------------------
	// external memory model
	// --------------------------------------------------
	initial begin : mem_model
		bit          busy;
		bit          req_seen;
		bit          resp_seen;
		int          lat;
		logic [31:0] word;
		bus_req_t    cur;
		busy           = 1'b0;
		req_seen       = 1'b0;
		resp_seen      = 1'b0;
		lat            = 0;
		cur            = '0;
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp       = '0;
		forever begin
			@(negedge clock);
			if (resp_seen) begin
				mem_resp_valid = 1'b0;
				busy           = 1'b0;
			end
			if (req_seen) begin
				mem_req_count++;
				if (mem_words.exists(cur.addr[11:2])) begin
					word = mem_words[cur.addr[11:2]];
				end else begin
					word = fill_word(cur.addr);
				end
				mem_resp.rdata = '0;
				if (cur.op == OP_WRITE) begin
					for (int i = 0; i < 4; i++) begin
						if (cur.wstrb[i]) begin
							word[8*i +: 8] = cur.wdata[8*i +: 8];
						end
					end
					mem_words[cur.addr[11:2]] = word;
				end else begin
					mem_resp.rdata = word;
				end
				mem_resp.resp = RESP_OKAY;
				lat           = int'($urandom % 4);
				busy          = 1'b1;
			end
			if (busy && !mem_resp_valid) begin
				if (lat == 0) begin
					mem_resp_valid = 1'b1;
				end else begin
					lat--;
				end
			end
			// random gaps in request ready
			mem_req_ready = !busy && ($urandom % 4 != 0);
			#1;
			req_seen  = mem_req_valid && mem_req_ready;
			resp_seen = mem_resp_valid && mem_resp_ready;
			if (req_seen) begin
				cur = mem_req;
			end
		end
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin : main
		bus_resp_t   r;
		bus_resp_t   r2;
		logic [31:0] old_word;
		logic [31:0] t0;
		logic [31:0] a;
		int unsigned mem_before;
		int unsigned prop_fails;
		void'($urandom(32'hca2f));
		rst_n          = 1'b0;
		ifu_req_valid  = 1'b0;
		ifu_req        = '0;
		ifu_resp_ready = 1'b0;
		lsu_req_valid  = 1'b0;
		lsu_req        = '0;
		lsu_resp_ready = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		#1;
		check_val("ifu_req_ready_o", 32'(ifu_req_ready), 32'd0);
		check_val("lsu_req_ready_o", 32'(lsu_req_ready), 32'd0);
		check_val("ifu_resp_valid_o", 32'(ifu_resp_valid), 32'd0);
		check_val("lsu_resp_valid_o", 32'(lsu_resp_valid), 32'd0);
		check_val("mem_req_valid_o", 32'(mem_req_valid), 32'd0);
		check_val("mem_resp_ready_o", 32'(mem_resp_ready), 32'd0);

		// tie right after reset, lsu wins
		fork
			run_transfer(1'b0, make_req(OP_READ, 32'h8000_0040, '0, '0), 1'b0, r);
			run_transfer(1'b1, make_req(OP_READ, 32'h8000_0080, '0, '0), 1'b0, r2);
		join
		check_resp("ifu_resp_o", r, make_resp(fill_word(32'h8000_0040), RESP_OKAY));
		check_resp("lsu_resp_o", r2, make_resp(fill_word(32'h8000_0080), RESP_OKAY));
		check_val("completions", done_q.size(), 32'd2);
		if (done_q.size() > 0) begin
			check_val("first_done_is_lsu", 32'(done_q[0]), 32'd1);
		end

		// partial store, then fetch it back
		old_word = fill_word(32'h8000_0100);
		run_transfer(1'b1, make_req(OP_WRITE, 32'h8000_0100, 32'hdead_beef, 4'b0101), 1'b0, r);
		check_val("lsu_resp_o.resp", 32'(r.resp), 32'(RESP_OKAY));
		run_transfer(1'b0, make_req(OP_READ, 32'h8000_0100, '0, '0), 1'b0, r);
		check_val("ifu_resp_o.rdata", r.rdata,
			{old_word[31:24], 8'had, old_word[15:8], 8'hef});

		// unmapped addresses
		mem_before = mem_req_count;
		run_transfer(1'b1, make_req(OP_WRITE, 32'h1000_0000, 32'h1234_5678, 4'hf), 1'b0, r);
		check_resp("lsu_resp_o", r, make_resp('0, RESP_DECERR));
		run_transfer(1'b0, make_req(OP_READ, 32'h4000_0000, '0, '0), 1'b0, r);
		check_resp("ifu_resp_o", r, make_resp('0, RESP_DECERR));
		check_val("mem_req_count", mem_req_count, mem_before);

		// mtime
		run_transfer(1'b1, make_req(OP_READ, mtime_lo_addr, '0, '0), 1'b0, r);
		t0 = r.rdata;
		run_transfer(1'b1, make_req(OP_READ, mtime_lo_addr, '0, '0), 1'b0, r);
		assert (r.rdata > t0) else begin
			mismatches++;
			$display("mismatch mtime_lo: got %h expected above %h", r.rdata, t0);
		end
		run_transfer(1'b1, make_req(OP_WRITE, mtime_hi_addr, 32'h1357_9bdf, 4'hf), 1'b0, r);
		check_resp("lsu_resp_o", r, make_resp('0, RESP_OKAY));
		run_transfer(1'b0, make_req(OP_READ, mtime_hi_addr, '0, '0), 1'b0, r);
		check_resp("ifu_resp_o", r, make_resp(32'h1357_9bdf, RESP_OKAY));
		run_transfer(1'b1, make_req(OP_READ, `CB_CLINT_BASE | 32'h10, '0, '0), 1'b0, r);
		check_val("lsu_resp_o.resp", 32'(r.resp), 32'(RESP_SLVERR));

		// back-pressure on both masters
		for (int i = 0; i < 6; i++) begin
			a = 32'h8000_0200 + 32'(i * 4);
			fork
				run_transfer(1'b1, make_req(OP_READ, a, '0, '0), 1'b1, r);
				run_transfer(1'b0, make_req(OP_READ, mtime_lo_addr, '0, '0), 1'b1, r2);
			join
			check_resp("lsu_resp_o", r, make_resp(fill_word(a), RESP_OKAY));
			check_val("ifu_resp_o.resp", 32'(r2.resp), 32'(RESP_OKAY));
		end

		repeat (2) @(negedge clock);
		prop_fails = u_dut.u_arbiter.u_arb_props.fail_cnt
			+ u_dut.u_xbar.u_xbar_props.fail_cnt;
		$display("errors: %0d mismatches, %0d timeouts, %0d property failures",
			mismatches, timeouts, prop_fails);
		if (mismatches == 0 && timeouts == 0 && prop_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* include/core_bus_defines.svh */
`ifndef CORE_BUS_DEFINES_SVH
`define CORE_BUS_DEFINES_SVH

// --------------------------------------------------
// bus widths, fixed by rv32
// --------------------------------------------------
`define CB_ADDR_W 32
`define CB_DATA_W 32
`define CB_STRB_W 4

// --------------------------------------------------
// address map
// --------------------------------------------------
// clint window, 64 KiB
`define CB_CLINT_BASE 32'h0200_0000
`define CB_CLINT_MASK 32'h0000_FFFF

// mtime register offsets inside the clint window
`define CB_MTIME_LO_OFF 16'hBFF8
`define CB_MTIME_HI_OFF 16'hBFFC

// external memory window, 256 MiB
`define CB_MEM_BASE 32'h8000_0000
`define CB_MEM_MASK 32'h0FFF_FFFF

`endif
